//--- Makefile
TOP := tb_wb_mem_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f wb_mem_subsystem.f \
	  --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	@out=$$(./obj_dir/sim 2>&1); echo "$$out"; \
	  echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

//--- common/wb_mem_pkg.sv
`default_nettype none

package wb_mem_pkg;

  // bus widths shared by the master, the interconnect and the slave.
  localparam int ADR_W = 32;
  localparam int DAT_W = 32;
  localparam int SEL_W = 4;

  // one select bit covers one byte lane of the data bus.
  localparam int BYTE_W = DAT_W / SEL_W;

  // number of address bits below the word index.
  localparam int BYTE_LSB = $clog2(SEL_W);

  // command opcode as given on the command side.
  typedef enum logic {
    WB_OP_READ  = 1'b0,
    WB_OP_WRITE = 1'b1
  } wb_op_t;

  // status returned with every response pulse.
  // a timeout also covers accesses outside the memory window.
  typedef enum logic {
    WB_ST_OK      = 1'b0,
    WB_ST_TIMEOUT = 1'b1
  } wb_status_t;

endpackage

`default_nettype wire

//--- src/wb_cmd_master.sv
`timescale 1ns/1ps
`default_nettype none

module wb_cmd_master #(
  parameter int TIMEOUT_CYCLES = 16
) (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               i_cmd_valid,
  input  wire wb_mem_pkg::wb_op_t           i_cmd_op,
  input  wire  [wb_mem_pkg::ADR_W-1:0]      i_cmd_adr,
  input  wire  [wb_mem_pkg::DAT_W-1:0]      i_cmd_dat,
  input  wire  [wb_mem_pkg::SEL_W-1:0]      i_cmd_sel,
  output logic                              o_busy,
  output logic                              o_rsp_valid,
  output wb_mem_pkg::wb_status_t            o_rsp_status,
  output logic [wb_mem_pkg::DAT_W-1:0]      o_rsp_dat,
  output logic                              o_wb_we,
  output logic                              o_wb_stb,
  output logic                              o_wb_cyc,
  output logic [wb_mem_pkg::SEL_W-1:0]      o_wb_sel,
  output logic [wb_mem_pkg::ADR_W-1:0]      o_wb_adr,
  output logic [wb_mem_pkg::DAT_W-1:0]      o_wb_dat,
  input  wire  [wb_mem_pkg::DAT_W-1:0]      i_wb_dat,
  input  wire                               i_wb_ack,
  input  wire                               i_wb_int,
  output logic                              o_irq
);

  import wb_mem_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    BUS,
    RESP
  } state_t;

  localparam int TO_W = $clog2(TIMEOUT_CYCLES + 1);

  state_t          state;
  logic [TO_W-1:0] to_cnt;
  logic            accept;
  logic            timed_out;

  assign o_busy      = (state == BUS);
  assign o_rsp_valid = (state == RESP);
  assign accept      = i_cmd_valid && !o_busy;

  // the timeout fires one edge after TIMEOUT_CYCLES edges without an ack.
  assign timed_out = (to_cnt == TO_W'(TIMEOUT_CYCLES));

  // a new command may also be taken in the response cycle, since busy is low there.
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      o_wb_cyc <= 1'b0;
      o_wb_stb <= 1'b0;
      o_wb_we  <= 1'b0;
      o_wb_sel <= '0;
      o_wb_adr <= '0;
      o_wb_dat <= '0;
      to_cnt   <= '0;
    end else begin
      case (state)
        IDLE, RESP: begin
          if (accept) begin
            state    <= BUS;
            o_wb_cyc <= 1'b1;
            o_wb_stb <= 1'b1;
            o_wb_we  <= (i_cmd_op == WB_OP_WRITE);
            o_wb_sel <= i_cmd_sel;
            o_wb_adr <= i_cmd_adr;
            o_wb_dat <= i_cmd_dat;
            to_cnt   <= '0;
          end else begin
            state <= IDLE;
          end
        end
        BUS: begin
          if (i_wb_ack || timed_out) begin
            state    <= RESP;
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
          end else begin
            to_cnt <= to_cnt + 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // response payload, captured on the edge that ends the bus cycle.
  always_ff @(posedge clk) begin
    if (state == BUS) begin
      if (i_wb_ack) begin
        o_rsp_status <= WB_ST_OK;
        o_rsp_dat    <= o_wb_we ? '0 : i_wb_dat;
      end else if (timed_out) begin
        o_rsp_status <= WB_ST_TIMEOUT;
        o_rsp_dat    <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_irq <= 1'b0;
    end else begin
      o_irq <= i_wb_int;
    end
  end

  a_stb_eq_cyc : assert property (@(posedge clk) disable iff (rst) o_wb_stb == o_wb_cyc);

  a_rsp_single : assert property (
    @(posedge clk) disable iff (rst) o_rsp_valid |=> !o_rsp_valid
  );

endmodule

`default_nettype wire

//--- src/wb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module wb_mem_subsystem #(
  parameter logic [wb_mem_pkg::ADR_W-1:0] MEM_OFFSET     = 32'h0000_1000,
  parameter int                           MEM_SIZE       = 256,
  parameter int                           DEPTH          = 64,
  parameter int                           WAIT_STATES    = 2,
  parameter int                           TIMEOUT_CYCLES = 16
) (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               i_cmd_valid,
  input  wire wb_mem_pkg::wb_op_t           i_cmd_op,
  input  wire  [wb_mem_pkg::ADR_W-1:0]      i_cmd_adr,
  input  wire  [wb_mem_pkg::DAT_W-1:0]      i_cmd_dat,
  input  wire  [wb_mem_pkg::SEL_W-1:0]      i_cmd_sel,
  output logic                              o_busy,
  output logic                              o_rsp_valid,
  output wb_mem_pkg::wb_status_t            o_rsp_status,
  output logic [wb_mem_pkg::DAT_W-1:0]      o_rsp_dat,
  output logic                              o_irq
);

  import wb_mem_pkg::*;

  // master side of the interconnect.
  logic             m_we;
  logic             m_stb;
  logic             m_cyc;
  logic [SEL_W-1:0] m_sel;
  logic [ADR_W-1:0] m_adr;
  logic [DAT_W-1:0] m_wdat;
  logic [DAT_W-1:0] m_rdat;
  logic             m_ack;
  logic             m_int;

  // slave side of the interconnect.
  logic             s0_we;
  logic             s0_stb;
  logic             s0_cyc;
  logic [SEL_W-1:0] s0_sel;
  logic [ADR_W-1:0] s0_adr;
  logic [DAT_W-1:0] s0_wdat;
  logic [DAT_W-1:0] s0_rdat;
  logic             s0_ack;
  logic             s0_int;

  wb_cmd_master #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) i_wb_cmd_master (
    .clk          (clk),
    .rst          (rst),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd_op     (i_cmd_op),
    .i_cmd_adr    (i_cmd_adr),
    .i_cmd_dat    (i_cmd_dat),
    .i_cmd_sel    (i_cmd_sel),
    .o_busy       (o_busy),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_status (o_rsp_status),
    .o_rsp_dat    (o_rsp_dat),
    .o_wb_we      (m_we),
    .o_wb_stb     (m_stb),
    .o_wb_cyc     (m_cyc),
    .o_wb_sel     (m_sel),
    .o_wb_adr     (m_adr),
    .o_wb_dat     (m_wdat),
    .i_wb_dat     (m_rdat),
    .i_wb_ack     (m_ack),
    .i_wb_int     (m_int),
    .o_irq        (o_irq)
  );

  wb_mem_interconnect #(
    .MEM_OFFSET (MEM_OFFSET),
    .MEM_SIZE   (MEM_SIZE)
  ) i_wb_mem_interconnect (
    .clk      (clk),
    .rst      (rst),
    .i_m_we   (m_we),
    .i_m_stb  (m_stb),
    .i_m_cyc  (m_cyc),
    .i_m_sel  (m_sel),
    .i_m_adr  (m_adr),
    .i_m_dat  (m_wdat),
    .o_m_dat  (m_rdat),
    .o_m_ack  (m_ack),
    .o_m_int  (m_int),
    .o_s0_we  (s0_we),
    .o_s0_cyc (s0_cyc),
    .o_s0_stb (s0_stb),
    .o_s0_sel (s0_sel),
    .o_s0_adr (s0_adr),
    .o_s0_dat (s0_wdat),
    .i_s0_ack (s0_ack),
    .i_s0_dat (s0_rdat),
    .i_s0_int (s0_int)
  );

  wb_sram_slave #(
    .DEPTH       (DEPTH),
    .WAIT_STATES (WAIT_STATES)
  ) i_wb_sram_slave (
    .clk   (clk),
    .rst   (rst),
    .i_we  (s0_we),
    .i_stb (s0_stb),
    .i_cyc (s0_cyc),
    .i_sel (s0_sel),
    .i_adr (s0_adr),
    .i_dat (s0_wdat),
    .o_dat (s0_rdat),
    .o_ack (s0_ack),
    .o_int (s0_int)
  );

endmodule

`default_nettype wire

//--- src/wb_sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module wb_sram_slave #(
  parameter int DEPTH       = 64,
  parameter int WAIT_STATES = 2
) (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            i_we,
  input  wire                            i_stb,
  input  wire                            i_cyc,
  input  wire  [wb_mem_pkg::SEL_W-1:0]   i_sel,
  input  wire  [wb_mem_pkg::ADR_W-1:0]   i_adr,
  input  wire  [wb_mem_pkg::DAT_W-1:0]   i_dat,
  output logic [wb_mem_pkg::DAT_W-1:0]   o_dat,
  output logic                           o_ack,
  output logic                           o_int
);

  import wb_mem_pkg::*;

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [DAT_W-1:0] mem [DEPTH];
  logic [IDX_W-1:0] word_idx;
  logic [CNT_W-1:0] wait_cnt;
  logic             req;
  logic             ack_now;
  logic             last_word;

  // the window base is aligned to its size, so the low bits index the words.
  assign word_idx = i_adr[BYTE_LSB +: IDX_W];

  // a request is pending until its ack has been given.
  assign req       = i_cyc && i_stb && !o_ack;
  assign ack_now   = req && (wait_cnt == CNT_W'(WAIT_STATES));
  assign last_word = (word_idx == IDX_W'(DEPTH - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
      o_ack    <= 1'b0;
      o_int    <= 1'b0;
    end else begin
      o_ack <= ack_now;
      if (ack_now || !req) begin
        wait_cnt <= '0;
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
      // write sets the flag and read clears it.
      if (ack_now && last_word) begin
        o_int <= i_we;
      end
    end
  end

  // memory access happens on the edge that raises the ack.
  always_ff @(posedge clk) begin
    if (ack_now) begin
      if (i_we) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (i_sel[b]) begin
            mem[word_idx][b*BYTE_W +: BYTE_W] <= i_dat[b*BYTE_W +: BYTE_W];
          end
        end
      end else begin
        o_dat <= mem[word_idx];
      end
    end
  end

  // the master must hold the cycle until it has seen the ack.
  a_ack_in_cyc : assert property (@(posedge clk) disable iff (rst) o_ack |-> i_cyc);

endmodule

`default_nettype wire

//--- verif/tb_wb_mem_table.svh
`ifndef TB_WB_MEM_TABLE_SVH
`define TB_WB_MEM_TABLE_SVH

  // one row per command, with the columns
  // opcode, address, write data, byte select, status, read data, o_irq after the response.
  wb_op_t           tbl_op   [$];
  logic [ADR_W-1:0] tbl_adr  [$];
  logic [DAT_W-1:0] tbl_dat  [$];
  logic [SEL_W-1:0] tbl_sel  [$];
  wb_status_t       tbl_st   [$];
  logic [DAT_W-1:0] tbl_rdat [$];
  logic             tbl_irq  [$];

  task automatic add_row(input wb_op_t op, input logic [ADR_W-1:0] adr,
                         input logic [DAT_W-1:0] dat, input logic [SEL_W-1:0] sel,
                         input wb_status_t st, input logic [DAT_W-1:0] rdat,
                         input logic irq);
    tbl_op.push_back(op);
    tbl_adr.push_back(adr);
    tbl_dat.push_back(dat);
    tbl_sel.push_back(sel);
    tbl_st.push_back(st);
    tbl_rdat.push_back(rdat);
    tbl_irq.push_back(irq);
  endtask

  task automatic load_table();
    add_row(WB_OP_WRITE, 32'h0000_1000, 32'h1234_5678, 4'hf, WB_ST_OK, 32'h0, 1'b0);
    add_row(WB_OP_READ,  32'h0000_1000, 32'h0,         4'hf, WB_ST_OK, 32'h1234_5678, 1'b0);
    // partial writes merge into the word already there.
    add_row(WB_OP_WRITE, 32'h0000_1004, 32'ha5a5_a5a5, 4'hf, WB_ST_OK, 32'h0, 1'b0);
    add_row(WB_OP_WRITE, 32'h0000_1004, 32'h1122_3344, 4'h5, WB_ST_OK, 32'h0, 1'b0);
    add_row(WB_OP_READ,  32'h0000_1004, 32'h0,         4'hf, WB_ST_OK, 32'ha522_a544, 1'b0);
    add_row(WB_OP_WRITE, 32'h0000_1008, 32'hffff_0000, 4'hf, WB_ST_OK, 32'h0, 1'b0);
    add_row(WB_OP_WRITE, 32'h0000_1008, 32'h0000_00aa, 4'h8, WB_ST_OK, 32'h0, 1'b0);
    add_row(WB_OP_READ,  32'h0000_1008, 32'h0,         4'hf, WB_ST_OK, 32'h00ff_0000, 1'b0);
    // just below and just above the window; 0x1100 would alias word 0 without the decoder.
    add_row(WB_OP_WRITE, 32'h0000_0ffc, 32'hbad0_bad0, 4'hf, WB_ST_TIMEOUT, 32'h0, 1'b0);
    add_row(WB_OP_WRITE, 32'h0000_1100, 32'hbad1_bad1, 4'hf, WB_ST_TIMEOUT, 32'h0, 1'b0);
    add_row(WB_OP_READ,  32'h0000_1100, 32'h0,         4'hf, WB_ST_TIMEOUT, 32'h0, 1'b0);
    add_row(WB_OP_READ,  32'h0000_1000, 32'h0,         4'hf, WB_ST_OK, 32'h1234_5678, 1'b0);
    add_row(WB_OP_READ,  32'h0000_1004, 32'h0,         4'hf, WB_ST_OK, 32'ha522_a544, 1'b0);
    // the last word raises the interrupt, other words leave it alone.
    add_row(WB_OP_WRITE, 32'h0000_10fc, 32'hcafe_f00d, 4'hf, WB_ST_OK, 32'h0, 1'b1);
    add_row(WB_OP_WRITE, 32'h0000_1010, 32'h0101_0101, 4'hf, WB_ST_OK, 32'h0, 1'b1);
    add_row(WB_OP_READ,  32'h0000_1010, 32'h0,         4'hf, WB_ST_OK, 32'h0101_0101, 1'b1);
    // the interconnect hides the interrupt while the master points outside the window.
    add_row(WB_OP_READ,  32'h0000_0000, 32'h0,         4'hf, WB_ST_TIMEOUT, 32'h0, 1'b0);
    add_row(WB_OP_READ,  32'h0000_1010, 32'h0,         4'hf, WB_ST_OK, 32'h0101_0101, 1'b1);
    add_row(WB_OP_READ,  32'h0000_10fc, 32'h0,         4'hf, WB_ST_OK, 32'hcafe_f00d, 1'b0);
    add_row(WB_OP_WRITE, 32'h0000_1014, 32'h5a5a_5a5a, 4'hf, WB_ST_OK, 32'h0, 1'b0);
    add_row(WB_OP_READ,  32'h2000_1000, 32'h0,         4'hf, WB_ST_TIMEOUT, 32'h0, 1'b0);
    add_row(WB_OP_WRITE, 32'h0000_10fc, 32'h0000_0001, 4'hf, WB_ST_OK, 32'h0, 1'b1);
  endtask

`endif

//--- verif/tb_wb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem_subsystem;

  import wb_mem_pkg::*;

  localparam logic [ADR_W-1:0] MEM_OFFSET     = 32'h0000_1000;
  localparam int               MEM_SIZE       = 256;
  localparam int               DEPTH          = 64;
  localparam int               WAIT_STATES    = 2;
  localparam int               TIMEOUT_CYCLES = 16;

  // response latency for a mapped and for an unmapped address.
  localparam int LAT_MAPPED   = WAIT_STATES + 3;
  localparam int LAT_UNMAPPED = TIMEOUT_CYCLES + 2;
  localparam int RESET_LIMIT  = 32;
  localparam int BUSY_LIMIT   = TIMEOUT_CYCLES + 8;
  localparam int RAND_OPS     = 300;

  logic             clk;
  logic             rst;
  logic             i_cmd_valid;
  wb_op_t           i_cmd_op;
  logic [ADR_W-1:0] i_cmd_adr;
  logic [DAT_W-1:0] i_cmd_dat;
  logic [SEL_W-1:0] i_cmd_sel;
  logic             o_busy;
  logic             o_rsp_valid;
  wb_status_t       o_rsp_status;
  logic [DAT_W-1:0] o_rsp_dat;
  logic             o_irq;

  // reference model of the SRAM and its interrupt flag.
  logic [DAT_W-1:0] model_mem [DEPTH];
  bit               written   [DEPTH];
  bit               model_irq;
  logic [ADR_W-1:0] last_adr;
  logic [31:0]      rng_state;

  `include "tb_wb_mem_table.svh"

  wb_mem_subsystem #(
    .MEM_OFFSET     (MEM_OFFSET),
    .MEM_SIZE       (MEM_SIZE),
    .DEPTH          (DEPTH),
    .WAIT_STATES    (WAIT_STATES),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) i_wb_mem_subsystem (
    .clk          (clk),
    .rst          (rst),
    .i_cmd_valid  (i_cmd_valid),
    .i_cmd_op     (i_cmd_op),
    .i_cmd_adr    (i_cmd_adr),
    .i_cmd_dat    (i_cmd_dat),
    .i_cmd_sel    (i_cmd_sel),
    .o_busy       (o_busy),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_status (o_rsp_status),
    .o_rsp_dat    (o_rsp_dat),
    .o_irq        (o_irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic bit in_window(input logic [ADR_W-1:0] adr);
    return ({1'b0, adr} >= {1'b0, MEM_OFFSET}) &&
           ({1'b0, adr} < ({1'b0, MEM_OFFSET} + (ADR_W + 1)'(MEM_SIZE)));
  endfunction

  function automatic int word_of(input logic [ADR_W-1:0] adr);
    return int'((adr - MEM_OFFSET) / SEL_W);
  endfunction

  // the interrupt is only visible while the master's address is mapped.
  function automatic logic model_irq_seen();
    return model_irq && in_window(last_adr);
  endfunction

  task automatic model_apply(input wb_op_t op, input logic [ADR_W-1:0] adr,
                             input logic [DAT_W-1:0] dat, input logic [SEL_W-1:0] sel);
    int idx;
    last_adr = adr;
    if (in_window(adr)) begin
      idx = word_of(adr);
      if (op == WB_OP_WRITE) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (sel[b]) begin
            model_mem[idx][b*8 +: 8] = dat[b*8 +: 8];
          end
        end
        written[idx] = 1'b1;
        if (idx == DEPTH - 1) begin
          model_irq = 1'b1;
        end
      end else if (idx == DEPTH - 1) begin
        model_irq = 1'b0;
      end
    end
  endtask

  task automatic fail_value(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic fail_plain(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopped because the DUT did not respond");
  endtask

  task automatic check_status(input wb_status_t act, input wb_status_t exp, input string what);
    if (act !== exp) begin
      fail_value($sformatf("%s status %s, expected %s", what, act.name(), exp.name()));
    end
  endtask

  task automatic check_data(input logic [DAT_W-1:0] act, input logic [DAT_W-1:0] exp,
                            input string what);
    if (act !== exp) begin
      fail_value($sformatf("%s read data %h, expected %h", what, act, exp));
    end
  endtask

  task automatic check_irq(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      fail_value($sformatf("%s o_irq %b, expected %b", what, act, exp));
    end
  endtask

  task automatic check_cycles(input int act, input int exp, input string what);
    if (act != exp) begin
      fail_value($sformatf("%s response after %0d cycles, expected %0d", what, act, exp));
    end
  endtask

  // called on a falling edge, returns on the falling edge after the response pulse.
  task automatic run_cmd(input wb_op_t op, input logic [ADR_W-1:0] adr,
                         input logic [DAT_W-1:0] dat, input logic [SEL_W-1:0] sel,
                         output wb_status_t st, output logic [DAT_W-1:0] rdat,
                         output logic irq, output int cycles);
    int waited;
    waited = 0;
    while (o_busy !== 1'b0) begin
      if (waited >= BUSY_LIMIT) begin
        fail_plain("o_busy stayed high and no new command could be given");
      end
      @(negedge clk);
      waited++;
    end
    i_cmd_valid = 1'b1;
    i_cmd_op    = op;
    i_cmd_adr   = adr;
    i_cmd_dat   = dat;
    i_cmd_sel   = sel;
    @(negedge clk);
    i_cmd_valid = 1'b0;
    cycles      = 1;
    if (o_busy !== 1'b1) begin
      fail_value($sformatf("o_busy did not rise after a command to %h", adr));
    end
    while (o_rsp_valid !== 1'b1) begin
      if (cycles >= LAT_UNMAPPED) begin
        fail_plain($sformatf("no response to the command at %h", adr));
      end
      @(negedge clk);
      cycles++;
    end
    st   = o_rsp_status;
    rdat = o_rsp_dat;
    irq  = o_irq;
    @(negedge clk);
    if (o_rsp_valid !== 1'b0) begin
      fail_value($sformatf("second o_rsp_valid pulse for the command at %h", adr));
    end
  endtask

  initial begin
    wb_status_t       st;
    logic [DAT_W-1:0] rdat;
    logic             irq;
    int               cycles;
    int               waited;
    int               idx;
    wb_op_t           op;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] dat;
    logic [SEL_W-1:0] sel;
    logic [DAT_W-1:0] exp_dat;

    i_cmd_valid = 1'b0;
    i_cmd_op    = WB_OP_READ;
    i_cmd_adr   = '0;
    i_cmd_dat   = '0;
    i_cmd_sel   = '0;
    model_irq   = 1'b0;
    last_adr    = '0;
    rng_state   = 32'h4843_613e;
    for (int i = 0; i < DEPTH; i++) begin
      written[i] = 1'b0;
    end

    waited = 0;
    while (rst !== 1'b0) begin
      if (waited >= RESET_LIMIT) begin
        fail_plain("reset was never released");
      end
      @(negedge clk);
      waited++;
    end
    @(negedge clk);
    if (o_busy !== 1'b0 || o_rsp_valid !== 1'b0) begin
      fail_value("o_busy or o_rsp_valid high after reset");
    end
    check_irq(o_irq, 1'b0, "after reset");

    load_table();
    for (int r = 0; r < tbl_op.size(); r++) begin
      run_cmd(tbl_op[r], tbl_adr[r], tbl_dat[r], tbl_sel[r], st, rdat, irq, cycles);
      check_status(st, tbl_st[r], $sformatf("row %0d", r));
      check_data(rdat, tbl_rdat[r], $sformatf("row %0d", r));
      check_irq(irq, tbl_irq[r], $sformatf("row %0d", r));
      check_cycles(cycles, in_window(tbl_adr[r]) ? LAT_MAPPED : LAT_UNMAPPED,
                   $sformatf("row %0d", r));
      model_apply(tbl_op[r], tbl_adr[r], tbl_dat[r], tbl_sel[r]);
    end

    // words never written hold no known value, so the first access to one is a full write.
    for (int i = 0; i < RAND_OPS; i++) begin
      rng_state = lcg_next(rng_state);
      idx       = int'(rng_state[29:24]) % DEPTH;
      op        = rng_state[31] ? WB_OP_WRITE : WB_OP_READ;
      sel       = rng_state[19:16];
      rng_state = lcg_next(rng_state);
      dat       = rng_state;
      if (!written[idx]) begin
        op  = WB_OP_WRITE;
        sel = '1;
      end
      adr     = MEM_OFFSET + ADR_W'(idx * SEL_W);
      exp_dat = (op == WB_OP_READ) ? model_mem[idx] : '0;
      model_apply(op, adr, dat, sel);
      run_cmd(op, adr, dat, sel, st, rdat, irq, cycles);
      check_status(st, WB_ST_OK, $sformatf("random op %0d", i));
      check_data(rdat, exp_dat, $sformatf("random op %0d", i));
      check_irq(irq, model_irq_seen(), $sformatf("random op %0d", i));
      check_cycles(cycles, LAT_MAPPED, $sformatf("random op %0d", i));
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- wb_mem_interconnect/wb_mem_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module wb_mem_interconnect #(
  parameter logic [wb_mem_pkg::ADR_W-1:0] MEM_OFFSET = 32'h0000_1000,
  parameter int                           MEM_SIZE   = 256
) (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            i_m_we,
  input  wire                            i_m_stb,
  input  wire                            i_m_cyc,
  input  wire  [wb_mem_pkg::SEL_W-1:0]   i_m_sel,
  input  wire  [wb_mem_pkg::ADR_W-1:0]   i_m_adr,
  input  wire  [wb_mem_pkg::DAT_W-1:0]   i_m_dat,
  output logic [wb_mem_pkg::DAT_W-1:0]   o_m_dat,
  output logic                           o_m_ack,
  output logic                           o_m_int,
  output logic                           o_s0_we,
  output logic                           o_s0_cyc,
  output logic                           o_s0_stb,
  output logic [wb_mem_pkg::SEL_W-1:0]   o_s0_sel,
  output logic [wb_mem_pkg::ADR_W-1:0]   o_s0_adr,
  output logic [wb_mem_pkg::DAT_W-1:0]   o_s0_dat,
  input  wire                            i_s0_ack,
  input  wire  [wb_mem_pkg::DAT_W-1:0]   i_s0_dat,
  input  wire                            i_s0_int
);

  import wb_mem_pkg::*;

  // the window is a power of two and aligned, so a mask compare is enough.
  localparam logic [ADR_W-1:0] WIN_MASK = ADR_W'(MEM_SIZE - 1);

  // explicit bounds, one bit wider so the top of the window cannot wrap.
  localparam logic [ADR_W:0] WIN_LO = {1'b0, MEM_OFFSET};
  localparam logic [ADR_W:0] WIN_HI = WIN_LO + (ADR_W + 1)'(MEM_SIZE);

  logic in_window;
  logic s0_sel;

  assign in_window = ((i_m_adr & ~WIN_MASK) == MEM_OFFSET);

  always_comb begin
    if (rst) begin
      s0_sel = 1'b0;
    end else begin
      s0_sel = in_window;
    end
  end

  // return path back to the master.
  always_comb begin
    if (s0_sel) begin
      o_m_dat = i_s0_dat;
      o_m_ack = i_s0_ack;
      o_m_int = i_s0_int;
    end else begin
      o_m_dat = '0;
      o_m_ack = 1'b0;
      o_m_int = 1'b0;
    end
  end

  // forward path to the slave.
  assign o_s0_we  = s0_sel ? i_m_we  : 1'b0;
  assign o_s0_cyc = s0_sel ? i_m_cyc : 1'b0;
  assign o_s0_stb = s0_sel ? i_m_stb : 1'b0;
  assign o_s0_sel = s0_sel ? i_m_sel : '0;
  assign o_s0_adr = s0_sel ? i_m_adr : '0;
  assign o_s0_dat = s0_sel ? i_m_dat : '0;

  // cross-check the mask decode against a plain range compare.
  a_stb_in_window : assert property (
    @(posedge clk) o_s0_stb |-> (({1'b0, i_m_adr} >= WIN_LO) && ({1'b0, i_m_adr} < WIN_HI))
  );

endmodule

`default_nettype wire

//--- wb_mem_subsystem.f
+incdir+verif
common/wb_mem_pkg.sv
wb_mem_interconnect/wb_mem_interconnect.sv
src/wb_cmd_master.sv
src/wb_sram_slave.sv
src/wb_mem_subsystem.sv
verif/tb_wb_mem_subsystem.sv
